// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= zk_crypto.f
TB_TOP    ?= tb_zk_top
RTL_TOP   ?= zk_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/zk_aes_sbox.sv ====
/*
  AES S-box in both directions, computed rather than tabled:
  GF(2^8) inversion combined with the affine map or its inverse.
*/
module zk_aes_sbox import zk_isa_pkg::*; (
  input  logic       inv_i,
  input  logic [7:0] in_i,
  output logic [7:0] out_o
);

  function automatic logic [7:0] rotl8(logic [7:0] x, int unsigned n);
    return (x << n) | (x >> (8 - n));
  endfunction

  // x^254, which is zero for zero
  function automatic logic [7:0] gf_inv(logic [7:0] x);
    logic [7:0] x2;
    logic [7:0] x3;
    logic [7:0] x12;
    logic [7:0] x14;
    logic [7:0] x15;
    logic [7:0] x240;
    x2   = zk_gf_mul(x, x);
    x3   = zk_gf_mul(x2, x);
    x12  = zk_gf_mul(x3, x3);
    x12  = zk_gf_mul(x12, x12);
    x14  = zk_gf_mul(x12, x2);
    x15  = zk_gf_mul(x12, x3);
    x240 = x15;
    for (int i = 0; i < 4; i++) begin
      x240 = zk_gf_mul(x240, x240);
    end
    return zk_gf_mul(x240, x14);
  endfunction

  logic [7:0] inv_in;
  logic [7:0] inv_out;
  logic [7:0] fwd_affine;
  logic [7:0] rev_affine;

  assign rev_affine = rotl8(in_i, 1) ^ rotl8(in_i, 3) ^ rotl8(in_i, 6) ^ 8'h05;

  // Decrypt undoes the affine map before inverting
  assign inv_in  = inv_i ? rev_affine : in_i;
  assign inv_out = gf_inv(inv_in);

  assign fwd_affine = inv_out ^ rotl8(inv_out, 1) ^ rotl8(inv_out, 2) ^
                      rotl8(inv_out, 3) ^ rotl8(inv_out, 4) ^ 8'h63;

  assign out_o = inv_i ? inv_out : fwd_affine;

endmodule

// ==== logic/zk_exec.sv ====
/*
  Execute unit: pops one operation, computes the AES32 or SHA-2 result
  and returns it over the four-phase result port. Illegal codes give zero.
*/
module zk_exec import zk_isa_pkg::*; import zk_xfer_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  zk_req_if.consumer        req,
  output logic              res_req_o,
  output logic              res_val_o,
  output logic [31:0]       result_o,
  output logic [TAG_W-1:0]  tag_o,
  input  logic              res_ack_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_DROP
  } tx_state_e;

  function automatic logic [31:0] ror32(logic [31:0] x, int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  zk_op_e      op;
  logic [31:0] a;
  zk_operand_u opb;
  logic [31:0] b;

  assign op  = req.pop_data.op;
  assign a   = req.pop_data.opa;
  assign opb = req.pop_data.opb;
  assign b   = opb.word;

  // AES32 fields straight from the code bits
  logic       aes_sel;
  logic       dec;
  logic       mix;
  logic [1:0] bsel;
  logic [7:0] sel_byte;
  logic [7:0] sbox_out;

  assign aes_sel  = ~op[4];
  assign dec      = op[3];
  assign mix      = op[2];
  assign bsel     = op[1:0];
  assign sel_byte = opb.bytes[bsel];

  zk_aes_sbox sbox_inst (
    .inv_i (dec),
    .in_i  (sel_byte),
    .out_o (sbox_out)
  );

  logic [31:0] mixed;
  logic [31:0] sbox_mix;
  logic [31:0] rotated;
  logic [31:0] aes_res;

  // One MixColumns column from a single input byte
  always_comb begin
    if (dec) begin
      mixed = {zk_gf_mul(sbox_out, 8'h0b), zk_gf_mul(sbox_out, 8'h0d),
               zk_gf_mul(sbox_out, 8'h09), zk_gf_mul(sbox_out, 8'h0e)};
    end else begin
      mixed = {zk_gf_mul(sbox_out, 8'h03), sbox_out,
               sbox_out, zk_gf_mul(sbox_out, 8'h02)};
    end
  end

  assign sbox_mix = mix ? mixed : {24'h0, sbox_out};

  always_comb begin
    case (bsel)
      2'd1:    rotated = {sbox_mix[23:0], sbox_mix[31:24]};
      2'd2:    rotated = {sbox_mix[15:0], sbox_mix[31:16]};
      2'd3:    rotated = {sbox_mix[7:0], sbox_mix[31:8]};
      default: rotated = sbox_mix;
    endcase
  end

  assign aes_res = rotated ^ a;

  logic [31:0] comb_res;
  logic        comb_val;

  always_comb begin
    comb_val = 1'b1;
    comb_res = 32'h0;
    if (aes_sel) begin
      comb_res = aes_res;
    end else begin
      case (op)
        ZK_OP_SHA256_SUM0:  comb_res = ror32(a, 2) ^ ror32(a, 13) ^ ror32(a, 22);
        ZK_OP_SHA256_SUM1:  comb_res = ror32(a, 6) ^ ror32(a, 11) ^ ror32(a, 25);
        ZK_OP_SHA256_SIG0:  comb_res = ror32(a, 7) ^ ror32(a, 18) ^ (a >> 3);
        ZK_OP_SHA256_SIG1:  comb_res = ror32(a, 17) ^ ror32(a, 19) ^ (a >> 10);
        // SHA-512 halves take the other half from operand B
        ZK_OP_SHA512_SUM0R: comb_res = (a << 25) ^ (a << 30) ^ (a >> 28) ^
                                       (b >> 7) ^ (b >> 2) ^ (b << 4);
        ZK_OP_SHA512_SUM1R: comb_res = (a << 23) ^ (a >> 14) ^ (a >> 18) ^
                                       (b >> 9) ^ (b << 18) ^ (b << 14);
        ZK_OP_SHA512_SIG0L: comb_res = (a >> 1) ^ (a >> 7) ^ (a >> 8) ^
                                       (b << 31) ^ (b << 25) ^ (b << 24);
        ZK_OP_SHA512_SIG0H: comb_res = (a >> 1) ^ (a >> 7) ^ (a >> 8) ^
                                       (b << 31) ^ (b << 24);
        ZK_OP_SHA512_SIG1L: comb_res = (a << 3) ^ (a >> 6) ^ (a >> 19) ^
                                       (b >> 29) ^ (b << 26) ^ (b << 13);
        ZK_OP_SHA512_SIG1H: comb_res = (a << 3) ^ (a >> 6) ^ (a >> 19) ^
                                       (b >> 29) ^ (b << 13);
        default:            comb_val = 1'b0;
      endcase
    end
  end

  tx_state_e state_q;
  logic      pop;

  // Pop only with an entry present and the sender idle
  assign req.pop_ready = (state_q == S_IDLE) && req.pop_valid;
  assign pop           = req.pop_valid && req.pop_ready;

  always_ff @(posedge clk_i) begin
    if (pop) begin
      result_o  <= comb_res;
      res_val_o <= comb_val;
      tag_o     <= req.pop_data.tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (pop) begin
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          if (res_ack_i) begin
            state_q <= S_DROP;
          end
        end
        // Agent must release ack before the next result
        S_DROP: begin
          if (!res_ack_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign res_req_o = (state_q == S_REQ);

endmodule

// ==== logic/zk_isa_pkg.sv ====
/*
  Zkn operation codes, the operand B views and the GF(2^8) multiply
  shared by the S-box and the execute unit. Import where these are used.
*/
package zk_isa_pkg;

  // AES32 codes carry dec in bit 3, mix in bit 2 and byte select in [1:0]
  typedef enum logic [4:0] {
    ZK_OP_ES_B0     = 5'd0,
    ZK_OP_ES_B1     = 5'd1,
    ZK_OP_ES_B2     = 5'd2,
    ZK_OP_ES_B3     = 5'd3,
    ZK_OP_ESM_B0    = 5'd4,
    ZK_OP_ESM_B1    = 5'd5,
    ZK_OP_ESM_B2    = 5'd6,
    ZK_OP_ESM_B3    = 5'd7,
    ZK_OP_DS_B0     = 5'd8,
    ZK_OP_DS_B1     = 5'd9,
    ZK_OP_DS_B2     = 5'd10,
    ZK_OP_DS_B3     = 5'd11,
    ZK_OP_DSM_B0    = 5'd12,
    ZK_OP_DSM_B1    = 5'd13,
    ZK_OP_DSM_B2    = 5'd14,
    ZK_OP_DSM_B3    = 5'd15,
    ZK_OP_SHA256_SUM0 = 5'd16,
    ZK_OP_SHA256_SUM1 = 5'd17,
    ZK_OP_SHA256_SIG0 = 5'd18,
    ZK_OP_SHA256_SIG1 = 5'd19,
    ZK_OP_SHA512_SUM0R = 5'd20,
    ZK_OP_SHA512_SUM1R = 5'd21,
    ZK_OP_SHA512_SIG0L = 5'd22,
    ZK_OP_SHA512_SIG0H = 5'd23,
    ZK_OP_SHA512_SIG1L = 5'd24,
    ZK_OP_SHA512_SIG1H = 5'd25,
    ZK_OP_NONE      = 5'd31
  } zk_op_e;

  // Operand B: whole word for SHA-512, byte lanes for AES32
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } zk_operand_u;

  // Product in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] zk_gf_mul(logic [7:0] a, logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

endpackage

// ==== logic/zk_issue.sv ====
/*
  Four-phase receiver for the operation port. Each request is tagged
  and pushed into the buffer once; the acknowledge waits for space.
*/
module zk_issue import zk_isa_pkg::*; import zk_xfer_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          op_req_i,
  input  zk_op_e        op_i,
  input  logic [31:0]   opa_i,
  input  logic [31:0]   opb_i,
  output logic          op_ack_o,
  zk_req_if.producer    req
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACK,
    S_WAIT
  } rx_state_e;

  rx_state_e        state_q;
  logic [TAG_W-1:0] tag_q;
  logic             push;
  zk_req_t          entry;

  always_comb begin
    entry.op       = op_i;
    entry.opa      = opa_i;
    entry.opb.word = opb_i;
    entry.tag      = tag_q;
  end

  // Fields are taken straight from the port while the agent holds them
  assign req.push_valid = (state_q == S_IDLE) && op_req_i;
  assign req.push_data  = entry;
  assign push           = req.push_valid && req.push_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      tag_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (push) begin
            state_q <= S_ACK;
            tag_q   <= tag_q + 1'b1;
          end
        end
        // Ack stays up for at least two cycles
        S_ACK:   state_q <= S_WAIT;
        S_WAIT: begin
          if (!op_req_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign op_ack_o = (state_q == S_ACK) || (state_q == S_WAIT);

endmodule

// ==== logic/zk_op_fifo.sv ====
/*
  Circular request buffer between issue and execute. Push and pop
  may occur in the same cycle; an entry is visible one cycle after push.
*/
module zk_op_fifo import zk_xfer_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic       clk_i,
  input  logic       rst_i,
  zk_req_if.buffer   req
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  zk_req_t            mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               do_push;
  logic               do_pop;

  // Wrap works for depths that are not a power of two as well
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign req.push_ready = (count_q != CNT_W'(DEPTH));
  assign req.pop_valid  = (count_q != '0);
  assign req.pop_data   = mem[rd_ptr_q];

  assign do_push = req.push_valid && req.push_ready;
  assign do_pop  = req.pop_valid && req.pop_ready;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= req.push_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== logic/zk_req_if.sv ====
/*
  Request path inside the coprocessor: a valid/ready push side into
  the buffer and a valid/ready pop side out of it.
*/
interface zk_req_if import zk_xfer_pkg::*; ();

  logic    push_valid;
  logic    push_ready;
  zk_req_t push_data;

  logic    pop_valid;
  logic    pop_ready;
  zk_req_t pop_data;

  modport producer (output push_valid, output push_data, input push_ready);

  modport buffer (
    input  push_valid, input push_data, output push_ready,
    output pop_valid, output pop_data, input pop_ready
  );

  modport consumer (input pop_valid, input pop_data, output pop_ready);

endinterface

// ==== logic/zk_top.sv ====
/*
  Scalar crypto coprocessor top level: operation port in, tagged
  results out, both four-phase, with a request FIFO between them.
*/
module zk_top import zk_isa_pkg::*; import zk_xfer_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              op_req_i,
  input  zk_op_e            op_i,
  input  logic [31:0]       opa_i,
  input  logic [31:0]       opb_i,
  output logic              op_ack_o,

  output logic              res_req_o,
  input  logic              res_ack_i,
  output logic [31:0]       result_o,
  output logic              res_val_o,
  output logic [TAG_W-1:0]  tag_o
);

  zk_req_if req_bus ();

  zk_issue issue_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .op_req_i (op_req_i),
    .op_i     (op_i),
    .opa_i    (opa_i),
    .opb_i    (opb_i),
    .op_ack_o (op_ack_o),
    .req      (req_bus.producer)
  );

  zk_op_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) fifo_inst (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req   (req_bus.buffer)
  );

  zk_exec exec_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req       (req_bus.consumer),
    .res_req_o (res_req_o),
    .res_val_o (res_val_o),
    .result_o  (result_o),
    .tag_o     (tag_o),
    .res_ack_i (res_ack_i)
  );

endmodule

// ==== logic/zk_xfer_pkg.sv ====
/*
  Transport types for the request buffer: the sequence tag width
  and the record that travels from the issue stage to the execute unit.
*/
package zk_xfer_pkg;
  import zk_isa_pkg::*;

  localparam int TAG_W = 4;

  // One buffered operation, 73 bits
  typedef struct packed {
    zk_op_e            op;
    logic [31:0]       opa;
    zk_operand_u       opb;
    logic [TAG_W-1:0]  tag;
  } zk_req_t;

endpackage

// ==== testbench/tb_clkgen.sv ====
/*
  Clock and reset source for the coprocessor testbench. The clock runs
  at a 20 ns period and reset is held high for the first 8 rising edges.
*/
module tb_clkgen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Released just after an edge, ahead of the stimulus
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

// ==== testbench/tb_zk_top.sv ====
/*
  Testbench for the scalar crypto coprocessor. It sends random Zkn operations
  over the four-phase port and checks each tagged result against a local model.
*/
module tb_zk_top import zk_isa_pkg::*; import zk_xfer_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LIMIT    = 200;
  localparam int KIND_AES = 0;
  localparam int KIND_SHA = 1;
  localparam int KIND_MIX = 2;
  localparam int KIND_BAD = 3;

  logic             clk;
  logic             rst;
  logic             op_req;
  zk_op_e           op;
  logic [31:0]      opa;
  logic [31:0]      opb;
  logic             op_ack;
  logic             res_req;
  logic             res_ack;
  logic [31:0]      result;
  logic             res_val;
  logic [TAG_W-1:0] tag;

  typedef struct {
    logic [TAG_W-1:0] tag;
    logic [31:0]      res;
    logic             val;
  } expect_t;

  expect_t          exp_q[$];
  logic [31:0]      rng;
  // Acknowledge delays draw from their own stream
  logic [31:0]      ack_rng;
  logic [TAG_W-1:0] next_tag;
  int               checks;
  int               errors;
  int               stalls;
  logic             mon_en;

  tb_clkgen clkgen_inst (
    .clk_o (clk),
    .rst_o (rst)
  );

  zk_top #(
    .FIFO_DEPTH (4)
  ) zk_top_inst (
    .clk_i     (clk),
    .rst_i     (rst),
    .op_req_i  (op_req),
    .op_i      (op),
    .opa_i     (opa),
    .opb_i     (opb),
    .op_ack_o  (op_ack),
    .res_req_o (res_req),
    .res_ack_i (res_ack),
    .result_o  (result),
    .res_val_o (res_val),
    .tag_o     (tag)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Carry-less product, then reduction by 0x11b
  function automatic logic [7:0] gmul(logic [7:0] x, logic [7:0] y);
    logic [15:0] p;
    p = '0;
    for (int i = 0; i < 8; i++) begin
      if (y[i]) p = p ^ (16'(x) << i);
    end
    for (int i = 15; i >= 8; i--) begin
      if (p[i]) p = p ^ (16'h11b << (i - 8));
    end
    return p[7:0];
  endfunction

  function automatic logic [7:0] ginv(logic [7:0] x);
    logic [7:0] r;
    r = 8'h00;
    for (int y = 1; y < 256; y++) begin
      if (gmul(x, 8'(y)) == 8'h01) r = 8'(y);
    end
    return r;
  endfunction

  function automatic logic [7:0] sbox_ref(logic [7:0] x, logic inv);
    logic [7:0] t;
    logic [7:0] s;
    if (inv) begin
      for (int i = 0; i < 8; i++)
        t[i] = x[(i + 2) % 8] ^ x[(i + 5) % 8] ^ x[(i + 7) % 8];
      s = ginv(t ^ 8'h05);
    end else begin
      t = ginv(x);
      for (int i = 0; i < 8; i++)
        s[i] = t[i] ^ t[(i + 4) % 8] ^ t[(i + 5) % 8] ^ t[(i + 6) % 8] ^ t[(i + 7) % 8];
      s = s ^ 8'h63;
    end
    return s;
  endfunction

  function automatic logic [31:0] rotr(logic [31:0] x, int n);
    logic [63:0] d;
    d = {x, x} >> n;
    return d[31:0];
  endfunction

  function automatic logic [63:0] rotr64(logic [63:0] x, int n);
    logic [127:0] d;
    d = {x, x} >> n;
    return d[63:0];
  endfunction

  // SHA-512 Sigma0, Sigma1, sigma0 and sigma1 on a whole 64-bit word
  function automatic logic [63:0] sha512_word(zk_op_e code, logic [63:0] x);
    case (code)
      ZK_OP_SHA512_SUM0R: return rotr64(x, 28) ^ rotr64(x, 34) ^ rotr64(x, 39);
      ZK_OP_SHA512_SUM1R: return rotr64(x, 14) ^ rotr64(x, 18) ^ rotr64(x, 41);
      ZK_OP_SHA512_SIG0L,
      ZK_OP_SHA512_SIG0H: return rotr64(x, 1) ^ rotr64(x, 8) ^ (x >> 7);
      ZK_OP_SHA512_SIG1L,
      ZK_OP_SHA512_SIG1H: return rotr64(x, 19) ^ rotr64(x, 61) ^ (x >> 6);
      default:            return 64'h0;
    endcase
  endfunction

  // Returns {valid, result}
  function automatic logic [32:0] expected_result(zk_op_e code, logic [31:0] a,
                                                  logic [31:0] b);
    int         c;
    int         bs;
    logic [7:0] s;
    logic [31:0] col;
    logic [63:0] lo_w;
    logic [63:0] hi_w;
    c = int'(code);
    if (c < 16) begin
      bs = c % 4;
      s  = sbox_ref(b[8 * bs +: 8], c >= 8);
      if (c < 4 || (c >= 8 && c < 12))
        col = {24'h0, s};
      else if (c < 8)
        col = {gmul(s, 8'h03), s, s, gmul(s, 8'h02)};
      else
        col = {gmul(s, 8'h0b), gmul(s, 8'h0d), gmul(s, 8'h09), gmul(s, 8'h0e)};
      return {1'b1, a ^ rotr(col, 32 - 8 * bs)};
    end
    // Low halves see {b, a} as the 64-bit word, high halves {a, b}
    lo_w = sha512_word(code, {b, a});
    hi_w = sha512_word(code, {a, b});
    case (code)
      ZK_OP_SHA256_SUM0:  return {1'b1, rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)};
      ZK_OP_SHA256_SUM1:  return {1'b1, rotr(a, 6) ^ rotr(a, 11) ^ rotr(a, 25)};
      ZK_OP_SHA256_SIG0:  return {1'b1, rotr(a, 7) ^ rotr(a, 18) ^ (a >> 3)};
      ZK_OP_SHA256_SIG1:  return {1'b1, rotr(a, 17) ^ rotr(a, 19) ^ (a >> 10)};
      ZK_OP_SHA512_SUM0R,
      ZK_OP_SHA512_SUM1R,
      ZK_OP_SHA512_SIG0L,
      ZK_OP_SHA512_SIG1L: return {1'b1, lo_w[31:0]};
      ZK_OP_SHA512_SIG0H,
      ZK_OP_SHA512_SIG1H: return {1'b1, hi_w[63:32]};
      default:            return 33'h0;
    endcase
  endfunction

  function automatic zk_op_e pick_op(int kind);
    logic [31:0] r;
    rng = xorshift32(rng);
    r   = rng;
    case (kind)
      KIND_AES: return zk_op_e'(5'(r % 16));
      KIND_SHA: return zk_op_e'(5'(16 + r % 10));
      KIND_MIX: return zk_op_e'(5'((r[3:0] == 0) ? 26 + r[31:8] % 6 : r[31:8] % 26));
      default:  return zk_op_e'(5'(r[0] ? 26 + r[31:8] % 6 : r[31:8] % 26));
    endcase
  endfunction

  function automatic logic probe(int which);
    case (which)
      0:       return op_ack;
      1:       return res_req;
      default: return rst;
    endcase
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  // 0 op_ack_o, 1 res_req_o, 2 reset
  task automatic wait_for(int which, logic level, string what, output int cycles);
    cycles = 0;
    while (probe(which) !== level && cycles < LIMIT) begin
      tick();
      cycles++;
    end
    if (probe(which) !== level) begin
      $display("Timeout after %0d cycles waiting for %s", LIMIT, what);
      $display("test failed");
      $finish;
    end
  endtask

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %0t %s: expected %08h, actual %08h", $time, what, exp, act);
    end
  endtask

  task automatic send_op(zk_op_e code, logic [31:0] a, logic [31:0] b);
    logic [32:0] m;
    int          waited;
    m = expected_result(code, a, b);
    exp_q.push_back('{tag: next_tag, res: m[31:0], val: m[32]});
    next_tag = next_tag + 1'b1;
    op     = code;
    opa    = a;
    opb    = b;
    op_req = 1'b1;
    wait_for(0, 1'b1, "op_ack_o to rise", waited);
    if (waited > 1) stalls++;
    op_req = 1'b0;
    wait_for(0, 1'b0, "op_ack_o to fall", waited);
  endtask

  task automatic send_batch(int n, int kind);
    zk_op_e      code;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < n; i++) begin
      code = pick_op(kind);
      rng  = xorshift32(rng);
      a    = rng;
      rng  = xorshift32(rng);
      b    = rng;
      send_op(code, a, b);
    end
  endtask

  task automatic collect(int n, int max_delay);
    expect_t     e;
    logic [31:0] held;
    int          waited;
    int          delay;
    for (int i = 0; i < n; i++) begin
      wait_for(1, 1'b1, "res_req_o to rise", waited);
      if (exp_q.size() == 0) begin
        errors++;
        $display("Result with tag %0d arrived with no operation outstanding", tag);
      end else begin
        e = exp_q.pop_front();
        check_value("tag", 32'(e.tag), 32'(tag));
        check_value("valid", 32'(e.val), 32'(res_val));
        check_value("result", e.res, result);
      end
      held    = result;
      ack_rng = xorshift32(ack_rng);
      delay   = (max_delay > 0) ? int'(ack_rng % (max_delay + 1)) : 0;
      repeat (delay) tick();
      check_value("held result", held, result);
      res_ack = 1'b1;
      wait_for(1, 1'b0, "res_req_o to fall", waited);
      // Agent may keep the acknowledge up a little after the request drops
      repeat (delay % 3) tick();
      res_ack = 1'b0;
    end
  endtask

  task automatic reset_test();
    int waited;
    int err0;
    err0 = errors;
    wait_for(2, 1'b0, "reset release", waited);
    mon_en = 1'b1;
    for (int i = 0; i < 4; i++) begin
      check_value("op_ack_o after reset", 0, 32'(op_ack));
      check_value("res_req_o after reset", 0, 32'(res_req));
      tick();
    end
    $display("reset: %0d errors", errors - err0);
  endtask

  task automatic run_test(string name, int n, int kind, int max_delay, bit need_stall);
    int err0;
    err0   = errors;
    stalls = 0;
    fork
      send_batch(n, kind);
      collect(n, max_delay);
    join
    // No further result may follow the last one
    for (int i = 0; i < 4; i++) begin
      tick();
      check_value("res_req_o idle", 0, 32'(res_req));
    end
    checks++;
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%s: %0d operations never returned a result", name, exp_q.size());
    end
    checks++;
    assert (!need_stall || stalls > 0) else begin
      errors++;
      $display("%s: op_ack_o never stalled while results were held off", name);
    end
    $display("%s: %0d operations, %0d errors", name, n, errors - err0);
  endtask

  // Sampled between the clock edge and the stimulus update
  initial begin
    logic ack_prev;
    logic req_prev;
    ack_prev  = 1'b0;
    req_prev  = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (mon_en) begin
        assert (!(op_ack && !ack_prev && !op_req)) else begin
          errors++;
          $display("Protocol error at %0t: op_ack_o rose without op_req_i", $time);
        end
        assert (!(res_req && !req_prev && res_ack)) else begin
          errors++;
          $display("Protocol error at %0t: res_req_o rose while res_ack_i was high", $time);
        end
        assert (!(!res_req && req_prev && !res_ack)) else begin
          errors++;
          $display("Protocol error at %0t: res_req_o dropped before res_ack_i", $time);
        end
      end
      ack_prev  = op_ack;
      req_prev  = res_req;
    end
  end

  initial begin
    op_req   = 1'b0;
    op       = ZK_OP_NONE;
    opa      = '0;
    opb      = '0;
    res_ack  = 1'b0;
    rng      = 32'd81;
    ack_rng  = 32'd81;
    next_tag = '0;
    checks   = 0;
    errors   = 0;
    stalls   = 0;
    mon_en   = 1'b0;
    reset_test();
    run_test("aes32", 200, KIND_AES, 0, 1'b0);
    run_test("sha", 200, KIND_SHA, 0, 1'b0);
    run_test("ordering and backpressure", 60, KIND_MIX, 40, 1'b1);
    run_test("illegal codes", 40, KIND_BAD, 3, 1'b0);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== zk_crypto.f ====
logic/zk_isa_pkg.sv
logic/zk_xfer_pkg.sv
logic/zk_req_if.sv
logic/zk_issue.sv
logic/zk_op_fifo.sv
logic/zk_aes_sbox.sv
logic/zk_exec.sv
logic/zk_top.sv
testbench/tb_clkgen.sv
testbench/tb_zk_top.sv
